// ==== tb/mips_core_stim.txt ====
// instr    rdata    pc       we addr     wdata    wb reg data
// all hex; addr and wdata are compared only when we is 1, reg and data only when wb is 1
00000000 00000000 00003000 0 00000000 00000000 0 00 00000000
34011234 00000000 00003004 0 00000000 00000000 1 01 00001234
3c02abcd 00000000 00003008 0 00000000 00000000 1 02 abcd0000
34425678 00000000 0000300c 0 00000000 00000000 1 02 abcd5678
2423fffc 00000000 00003010 0 00000000 00000000 1 03 00001230
00232021 00000000 00003014 0 00000000 00000000 1 04 00002464
00612823 00000000 00003018 0 00000000 00000000 1 05 fffffffc
00a1302a 00000000 0000301c 0 00000000 00000000 1 06 00000001
0025382a 00000000 00003020 0 00000000 00000000 1 07 00000000
00230021 00000000 00003024 0 00000000 00000000 0 00 00000000
// addi with and without signed overflow
3c087fff 00000000 00003028 0 00000000 00000000 1 08 7fff0000
3508ffff 00000000 0000302c 0 00000000 00000000 1 08 7fffffff
210f0001 00000000 00003030 0 00000000 00000000 0 00 00000000
20290010 00000000 00003034 0 00000000 00000000 1 09 00001244
20aaffff 00000000 00003038 0 00000000 00000000 1 0a fffffffb
// stores and a load
ac220008 00000000 0000303c 1 0000123c abcd5678 0 00 00000000
ad24fffc 00000000 00003040 1 00001240 00002464 0 00 00000000
8c2b0004 deadbeef 00003044 0 00000000 00000000 1 0b deadbeef
// branches, taken forward, not taken, taken backward
10210002 00000000 00003048 0 00000000 00000000 0 00 00000000
10230005 00000000 00003054 0 00000000 00000000 0 00 00000000
10e0fffe 00000000 00003058 0 00000000 00000000 0 00 00000000
240c3070 00000000 00003054 0 00000000 00000000 1 0c 00003070
// jumps
08000c20 00000000 00003058 0 00000000 00000000 0 00 00000000
0c000c28 00000000 00003080 0 00000000 00000000 1 1f 00003084
01800008 00000000 000030a0 0 00000000 00000000 0 00 00000000
03e00008 00000000 00003070 0 00000000 00000000 0 00 00000000
03e06821 00000000 00003084 0 00000000 00000000 1 0d 00003084
// unsupported opcode, then read back earlier results
802e0000 12345678 00003088 0 00000000 00000000 0 00 00000000
01407021 00000000 0000308c 0 00000000 00000000 1 0e fffffffb
01e08021 00000000 00003090 0 00000000 00000000 1 10 00000000
00068821 00000000 00003094 0 00000000 00000000 1 11 00000001
ac0b0000 00000000 00003098 1 00000000 deadbeef 0 00 00000000
24200005 00000000 0000309c 0 00000000 00000000 0 00 00000000
00000000 00000000 000030a0 0 00000000 00000000 0 00 00000000

// ==== all.f ====
source/mips_isa_pkg.sv
source/mips_ctrl_pkg.sv
source/controller.sv
source/execute_unit.sv
source/result_unit.sv
source/pc_unit.sv
source/mips_core.sv
tb/mips_core_tb.sv

// ==== tb/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

    localparam logic [31:0] RESET_PC     = 32'h0000_3000;
    localparam int          NUM_VECTORS  = 34;
    localparam int          NUM_FIELDS   = 9;
    localparam int          RESET_CYCLES = 10;
    localparam int          CYCLE_LIMIT  = NUM_VECTORS + RESET_CYCLES + 20;

    // columns of one stimulus line
    localparam int COL_INSTR     = 0;
    localparam int COL_RDATA     = 1;
    localparam int COL_PC        = 2;
    localparam int COL_MEM_WE    = 3;
    localparam int COL_MEM_ADDR  = 4;
    localparam int COL_MEM_WDATA = 5;
    localparam int COL_WB_EN     = 6;
    localparam int COL_WB_REG    = 7;
    localparam int COL_WB_DATA   = 8;

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] mem_rdata;
    logic [31:0] pc;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    logic [31:0] vectors [NUM_VECTORS*NUM_FIELDS];
    int          cycle_count = 0;
    int          line_index  = 0;

    mips_core #(.RESET_PC(RESET_PC)) mips_core_inst (
        .clk(clk), .reset(reset), .instr(instr), .mem_rdata(mem_rdata),
        .pc(pc), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit, counted in clock cycles from time zero
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    function automatic logic [31:0] vector_field(input int line, input int column);
        return vectors[line*NUM_FIELDS + column];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s on line %0d is %h, expected %h",
                     name, line_index, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic check_outputs(input int line);
        logic [31:0] exp_mem_we;
        logic [31:0] exp_wb_en;
        exp_mem_we = vector_field(line, COL_MEM_WE);
        exp_wb_en  = vector_field(line, COL_WB_EN);
        compare_value("pc", pc, vector_field(line, COL_PC));
        compare_value("mem_we", {31'b0, mem_we}, exp_mem_we);
        if (exp_mem_we[0]) begin  // address and data only matter on a store
            compare_value("mem_addr", mem_addr, vector_field(line, COL_MEM_ADDR));
            compare_value("mem_wdata", mem_wdata, vector_field(line, COL_MEM_WDATA));
        end
        compare_value("wb_en", {31'b0, wb_en}, exp_wb_en);
        if (exp_wb_en[0]) begin
            compare_value("wb_reg", {27'b0, wb_reg}, vector_field(line, COL_WB_REG));
            compare_value("wb_data", wb_data, vector_field(line, COL_WB_DATA));
        end
    endtask

    initial begin
        reset     = 1'b1;
        instr     = '0;   // decodes as a no-op while reset is high
        mem_rdata = '0;
        $readmemh("tb/mips_core_stim.txt", vectors);
        if (vector_field(NUM_VECTORS-1, COL_PC) === 'x) begin
            $display("the stimulus file is missing or holds fewer lines than expected");
            $display("ERRORS FOUND");
            $fatal(1);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            line_index = i;
            instr      = vector_field(i, COL_INSTR);
            mem_rdata  = vector_field(i, COL_RDATA);
            #8;  // sample 1 ns before the edge that retires the instruction
            check_outputs(i);
            @(posedge clk);
            #1;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== source/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_3000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::word_t     instr,
    input  mips_isa_pkg::word_t     mem_rdata,
    output mips_isa_pkg::word_t     pc,
    output mips_isa_pkg::word_t     mem_addr,
    output mips_isa_pkg::word_t     mem_wdata,
    output logic                    mem_we,
    output logic                    wb_en,
    output mips_isa_pkg::reg_addr_t wb_reg,
    output mips_isa_pkg::word_t     wb_data
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    // instruction fields
    opcode_t              opcode;
    funct_t               funct;
    reg_addr_t            rs;
    reg_addr_t            rt;
    reg_addr_t            rd;
    logic [IMM_W-1:0]     imm16;
    logic [TARGET_W-1:0]  target26;

    // control
    reg_dst_t reg_dst;
    mem2reg_t mem2reg;
    npc_sel_t npc_sel;
    ext_op_t  ext_op;
    alu_op_t  alu_op;
    logic     alu_src;
    logic     reg_wr;
    logic     flag_op;

    // datapath
    word_t rs_data;
    word_t rt_data;
    word_t alu_result;
    logic  equal;
    logic  overflow;

    assign opcode   = opcode_t'(instr[OPCODE_LSB +: OPCODE_W]);
    assign funct    = funct_t'(instr[FUNCT_LSB +: FUNCT_W]);  // unknown codes fall to default
    assign rs       = instr[RS_LSB +: REG_ADDR_W];
    assign rt       = instr[RT_LSB +: REG_ADDR_W];
    assign rd       = instr[RD_LSB +: REG_ADDR_W];
    assign imm16    = instr[IMM_LSB +: IMM_W];
    assign target26 = instr[TARGET_LSB +: TARGET_W];

    assign mem_addr  = alu_result;
    assign mem_wdata = rt_data;

    controller controller_inst (
        .opcode(opcode), .funct(funct), .equal(equal),
        .reg_dst(reg_dst), .alu_src(alu_src), .mem2reg(mem2reg), .reg_wr(reg_wr),
        .mem_we(mem_we), .npc_sel(npc_sel), .ext_op(ext_op), .alu_op(alu_op),
        .flag_op(flag_op)
    );

    execute_unit execute_unit_inst (
        .imm16(imm16), .rs_data(rs_data), .rt_data(rt_data), .ext_op(ext_op),
        .alu_src(alu_src), .alu_op(alu_op),
        .alu_result(alu_result), .equal(equal), .overflow(overflow)
    );

    result_unit result_unit_inst (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt), .rd(rd),
        .reg_dst(reg_dst), .mem2reg(mem2reg), .reg_wr(reg_wr), .flag_op(flag_op),
        .overflow(overflow), .alu_result(alu_result), .mem_rdata(mem_rdata), .pc(pc),
        .rs_data(rs_data), .rt_data(rt_data),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    pc_unit #(.RESET_PC(RESET_PC)) pc_unit_inst (
        .clk(clk), .reset(reset), .npc_sel(npc_sel), .imm16(imm16),
        .target26(target26), .rs_data(rs_data), .pc(pc)
    );

endmodule

// ==== source/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit #(
    parameter mips_isa_pkg::word_t RESET_PC = 32'h0000_3000
) (
    input  logic                              clk,
    input  logic                              reset,
    input  mips_ctrl_pkg::npc_sel_t           npc_sel,
    input  logic [mips_isa_pkg::IMM_W-1:0]    imm16,
    input  logic [mips_isa_pkg::TARGET_W-1:0] target26,
    input  mips_isa_pkg::word_t               rs_data,
    output mips_isa_pkg::word_t               pc
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    word_t pc_plus4;
    word_t branch_offset;
    word_t next_pc;

    assign pc_plus4 = pc + 32'd4;

    // sign-extended word offset
    assign branch_offset = {{(WORD_W-IMM_W-2){imm16[IMM_W-1]}}, imm16, 2'b00};

    always_comb begin
        case (npc_sel)
            npc_branch: next_pc = pc_plus4 + branch_offset;
            npc_jump:   next_pc = {pc_plus4[WORD_W-1 -: 4], target26, 2'b00};
            npc_reg:    next_pc = rs_data;
            default:    next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // jr to a misaligned register value would break this
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

// ==== source/result_unit.sv ====
`timescale 1ns/1ps

module result_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  mips_isa_pkg::reg_addr_t rs,
    input  mips_isa_pkg::reg_addr_t rt,
    input  mips_isa_pkg::reg_addr_t rd,
    input  mips_ctrl_pkg::reg_dst_t reg_dst,
    input  mips_ctrl_pkg::mem2reg_t mem2reg,
    input  logic                    reg_wr,
    input  logic                    flag_op,
    input  logic                    overflow,
    input  mips_isa_pkg::word_t     alu_result,
    input  mips_isa_pkg::word_t     mem_rdata,
    input  mips_isa_pkg::word_t     pc,
    output mips_isa_pkg::word_t     rs_data,
    output mips_isa_pkg::word_t     rt_data,
    output logic                    wb_en,
    output mips_isa_pkg::reg_addr_t wb_reg,
    output mips_isa_pkg::word_t     wb_data
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    word_t regs [NUM_REGS];

    // asynchronous read ports
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    always_comb begin
        case (reg_dst)
            dst_rd:  wb_reg = rd;
            dst_ra:  wb_reg = reg_addr_t'(NUM_REGS - 1);
            default: wb_reg = rt;
        endcase
    end

    always_comb begin
        case (mem2reg)
            res_load: wb_data = mem_rdata;
            res_link: wb_data = pc + 32'd4;
            default:  wb_data = alu_result;
        endcase
    end

    // no write on addi overflow, none to register 0
    assign wb_en = reg_wr && !(flag_op && overflow) && (wb_reg != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // register 0 stays zero across every retired instruction
    a_reg0_zero: assert property (
        @(posedge clk) disable iff (reset)
        (rs == '0) |-> (rs_data == '0)
    );

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic [mips_isa_pkg::IMM_W-1:0] imm16,
    input  mips_isa_pkg::word_t            rs_data,
    input  mips_isa_pkg::word_t            rt_data,
    input  mips_ctrl_pkg::ext_op_t         ext_op,
    input  logic                           alu_src,
    input  mips_ctrl_pkg::alu_op_t         alu_op,
    output mips_isa_pkg::word_t            alu_result,
    output logic                           equal,
    output logic                           overflow
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    word_t imm_ext;
    word_t operand_b;
    word_t sum;
    logic  less;

    always_comb begin
        case (ext_op)
            ext_zero:  imm_ext = {{(WORD_W-IMM_W){1'b0}}, imm16};
            ext_sign:  imm_ext = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
            ext_upper: imm_ext = {imm16, {(WORD_W-IMM_W){1'b0}}};
            default:   imm_ext = '0;
        endcase
    end

    assign operand_b = alu_src ? imm_ext : rt_data;

    assign sum  = rs_data + operand_b;
    assign less = $signed(rs_data) < $signed(operand_b);

    always_comb begin
        case (alu_op)
            alu_add:    alu_result = sum;
            alu_sub:    alu_result = rs_data - operand_b;
            alu_or:     alu_result = rs_data | operand_b;
            alu_slt:    alu_result = {{(WORD_W-1){1'b0}}, less};
            alu_pass_b: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // operands of one sign, sum of the other
    assign overflow = (rs_data[WORD_W-1] == operand_b[WORD_W-1]) &&
                      (sum[WORD_W-1] != rs_data[WORD_W-1]);

    assign equal = (rs_data == rt_data);  // beq compares registers, not the alu

endmodule

// ==== source/controller.sv ====
`timescale 1ns/1ps

module controller (
    input  mips_isa_pkg::opcode_t   opcode,
    input  mips_isa_pkg::funct_t    funct,
    input  logic                    equal,
    output mips_ctrl_pkg::reg_dst_t reg_dst,
    output logic                    alu_src,
    output mips_ctrl_pkg::mem2reg_t mem2reg,
    output logic                    reg_wr,
    output logic                    mem_we,
    output mips_ctrl_pkg::npc_sel_t npc_sel,
    output mips_ctrl_pkg::ext_op_t  ext_op,
    output mips_ctrl_pkg::alu_op_t  alu_op,
    output logic                    flag_op
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        // defaults make anything not decoded below a no-op
        reg_dst = dst_rt;
        alu_src = 1'b0;
        mem2reg = res_alu;
        reg_wr  = 1'b0;
        mem_we  = 1'b0;
        npc_sel = npc_seq;
        ext_op  = ext_zero;
        alu_op  = alu_add;
        flag_op = 1'b0;

        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: begin
                        reg_dst = dst_rd;
                        reg_wr  = 1'b1;
                        alu_op  = alu_add;
                    end
                    fn_subu: begin
                        reg_dst = dst_rd;
                        reg_wr  = 1'b1;
                        alu_op  = alu_sub;
                    end
                    fn_slt: begin
                        reg_dst = dst_rd;
                        reg_wr  = 1'b1;
                        alu_op  = alu_slt;
                    end
                    fn_jr: begin
                        npc_sel = npc_reg;  // target comes from rs
                        alu_op  = alu_pass_b;
                    end
                    default: ;
                endcase
            end
            op_ori: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                ext_op  = ext_zero;
                alu_op  = alu_or;
            end
            op_lw: begin
                alu_src = 1'b1;
                mem2reg = res_load;
                reg_wr  = 1'b1;
                ext_op  = ext_sign;
                alu_op  = alu_add;  // base + offset
            end
            op_sw: begin
                alu_src = 1'b1;
                mem2reg = res_load;
                mem_we  = 1'b1;
                ext_op  = ext_sign;
                alu_op  = alu_add;
            end
            op_beq: begin
                alu_op  = alu_sub;
                npc_sel = equal ? npc_branch : npc_seq;
            end
            op_lui: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                ext_op  = ext_upper;
                alu_op  = alu_pass_b;  // rs field plays no part in lui
            end
            op_j: begin
                npc_sel = npc_jump;
            end
            op_addi: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                ext_op  = ext_sign;
                alu_op  = alu_add;
                flag_op = 1'b1;     // write dropped on signed overflow
            end
            op_addiu: begin
                alu_src = 1'b1;
                reg_wr  = 1'b1;
                ext_op  = ext_sign;
                alu_op  = alu_add;
            end
            op_jal: begin
                reg_dst = dst_ra;
                mem2reg = res_link;
                reg_wr  = 1'b1;
                npc_sel = npc_jump;
                alu_op  = alu_pass_b;
            end
            default: ;
        endcase
    end

    // a store never writes the register file in the same cycle
    a_no_reg_and_mem_write: assert final (!(reg_wr && mem_we));

endmodule

// ==== source/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

    // destination register of a write-back
    typedef enum logic [1:0] {
        dst_rt = 2'b00,
        dst_rd = 2'b01,
        dst_ra = 2'b10   // register 31, for jal
    } reg_dst_t;

    // source of the write-back value
    typedef enum logic [1:0] {
        res_alu  = 2'b00,
        res_load = 2'b01,
        res_link = 2'b10  // pc + 4
    } mem2reg_t;

    // next pc select
    typedef enum logic [1:0] {
        npc_seq    = 2'b00,
        npc_branch = 2'b01,
        npc_jump   = 2'b10,
        npc_reg    = 2'b11
    } npc_sel_t;

    // immediate extension
    typedef enum logic [1:0] {
        ext_zero  = 2'b00,
        ext_sign  = 2'b01,
        ext_upper = 2'b10  // imm16 in the upper half, low half zero
    } ext_op_t;

    // alu operation, 3'b010 is not used
    typedef enum logic [2:0] {
        alu_add    = 3'b000,
        alu_sub    = 3'b001,
        alu_or     = 3'b011,
        alu_slt    = 3'b100,
        alu_pass_b = 3'b101
    } alu_op_t;

    // the five control types above are everything the decoder hands out,
    // together with the single-bit alu_src, reg_wr, mem_we and flag_op

endpackage

// ==== source/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // architectural widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int IMM_W      = 16;
    localparam int TARGET_W   = 26;

    // field positions inside the instruction word (lsb of each field)
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM_LSB    = 0;
    localparam int TARGET_LSB = 0;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [OPCODE_W-1:0] {
        op_special = 6'b000000,  // r-type, look at funct
        op_j       = 6'b000010,
        op_jal     = 6'b000011,
        op_beq     = 6'b000100,
        op_addi    = 6'b001000,
        op_addiu   = 6'b001001,
        op_ori     = 6'b001101,
        op_lui     = 6'b001111,
        op_lw      = 6'b100011,
        op_sw      = 6'b101011
    } opcode_t;

    typedef enum logic [FUNCT_W-1:0] {
        fn_jr   = 6'b001000,
        fn_addu = 6'b100001,
        fn_subu = 6'b100011,
        fn_slt  = 6'b101010
    } funct_t;

endpackage
